// File: flist.f
logic/blit_pkg.sv
logic/blit_bus_if.sv
logic/blit_ram.sv
logic/blit_engine.sv
logic/blit_mem_arb.sv
logic/blit_top.sv
verif/blit_clkgen.sv
verif/blit_assert.sv
verif/blit_tb.sv

// File: logic/blit_bus_if.sv
// blitter memory request bus
// engine side issues one request at a time, arbiter answers with ack

`timescale 1ns/1ps

interface blit_bus_if;
    import blit_pkg::*;

    logic       sel;      // request valid, held until ack
    logic       xr;       // target XR rather than VRAM
    logic       wr;       // write request
    logic [3:0] wr_mask;  // nibble enables for writes
    addr_t      addr;
    word_t      wdata;
    word_t      rdata;    // valid with ack on reads
    logic       ack;      // one cycle, request completed

    modport engine (
        output sel, xr, wr, wr_mask, addr, wdata,
        input  rdata, ack
    );

    modport arb (
        input  sel, xr, wr, wr_mask, addr, wdata,
        output rdata, ack
    );

endinterface

// File: logic/blit_engine.sv
// blitter engine
// host register file with readback, one-deep job queue,
// copy/fill FSM driving the memory request bus

`timescale 1ns/1ps

module blit_engine (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  blit_pkg::blit_reg_t reg_num_i,
    input  blit_pkg::word_t     reg_data_i,
    output blit_pkg::word_t     reg_data_o,
    output logic                busy_o,
    output logic                done_intr_o,
    blit_bus_if.engine          bus
);
    import blit_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        COPY_READ,
        COPY_WRITE,
        FILL_WRITE,
        DONE
    } state_t;

    // host programmed registers
    logic       reg_rd_xr;
    logic       reg_wr_xr;
    logic       reg_fill;
    logic [3:0] reg_wr_mask;
    word_t      reg_rd_addr;   // fill value in fill mode
    addr_t      reg_wr_addr;
    word_t      reg_count;
    logic       queued;        // job waiting for SETUP

    // working copies, host may reprogram while busy
    state_t      state;
    logic        work_rd_xr;
    logic        work_wr_xr;
    addr_t       work_rd_addr;
    addr_t       work_wr_addr;
    logic [16:0] count;
    logic [16:0] count_dec;

    assign count_dec   = count - 1'b1;  // bit 16 set on underflow
    assign busy_o      = (state != IDLE);
    assign done_intr_o = (state == DONE);  // DONE always lasts one cycle

    // register writes and queue flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_rd_xr   <= 1'b0;
            reg_wr_xr   <= 1'b0;
            reg_fill    <= 1'b0;
            reg_wr_mask <= 4'hF;
            reg_rd_addr <= '0;
            reg_wr_addr <= '0;
            reg_count   <= '0;
            queued      <= 1'b0;
        end else begin
            if (state == SETUP) begin
                queued <= 1'b0;
            end
            // a COUNT write in the SETUP cycle wins over the clear
            if (reg_wr_i) begin
                case (reg_num_i)
                    BLIT_REG_MODE: begin
                        reg_rd_xr <= reg_data_i[MODE_RD_XR];
                        reg_wr_xr <= reg_data_i[MODE_WR_XR];
                        reg_fill  <= reg_data_i[MODE_FILL];
                    end
                    BLIT_REG_WR_MASK: reg_wr_mask <= reg_data_i[3:0];
                    BLIT_REG_RD_ADDR: reg_rd_addr <= reg_data_i;
                    BLIT_REG_WR_ADDR: reg_wr_addr <= reg_data_i;
                    BLIT_REG_COUNT: begin
                        reg_count <= reg_data_i;
                        queued    <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // registered readback, unused numbers give zero
    always_ff @(posedge clk) begin
        case (reg_num_i)
            BLIT_REG_MODE:    reg_data_o <= {reg_rd_xr, reg_wr_xr, reg_fill, 13'h0};
            BLIT_REG_WR_MASK: reg_data_o <= {12'h0, reg_wr_mask};
            BLIT_REG_RD_ADDR: reg_data_o <= reg_rd_addr;
            BLIT_REG_WR_ADDR: reg_data_o <= reg_wr_addr;
            BLIT_REG_COUNT:   reg_data_o <= reg_count;
            default:          reg_data_o <= '0;
        endcase
    end

    // copy/fill FSM
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= IDLE;
            bus.sel     <= 1'b0;
            bus.wr      <= 1'b0;
            bus.wr_mask <= 4'hF;
        end else begin
            case (state)
                IDLE: begin
                    if (queued) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    work_rd_xr  <= reg_rd_xr;
                    work_wr_xr  <= reg_wr_xr;
                    count       <= {1'b0, reg_count};
                    bus.wr_mask <= reg_wr_mask;  // held for the whole job
                    bus.sel     <= 1'b1;
                    if (reg_fill) begin
                        // first fill write goes out right away
                        bus.xr       <= reg_wr_xr;
                        bus.wr       <= 1'b1;
                        bus.addr     <= reg_wr_addr;
                        bus.wdata    <= reg_rd_addr;
                        work_wr_addr <= reg_wr_addr + 1'b1;
                        state        <= FILL_WRITE;
                    end else begin
                        bus.xr       <= reg_rd_xr;
                        bus.wr       <= 1'b0;
                        bus.addr     <= reg_rd_addr;
                        work_rd_addr <= reg_rd_addr + 1'b1;
                        work_wr_addr <= reg_wr_addr;
                        state        <= COPY_READ;
                    end
                end
                COPY_READ: begin
                    if (bus.ack) begin
                        // turn the read word straight into a write
                        bus.xr       <= work_wr_xr;
                        bus.wr       <= 1'b1;
                        bus.addr     <= work_wr_addr;
                        bus.wdata    <= bus.rdata;
                        work_wr_addr <= work_wr_addr + 1'b1;
                        state        <= COPY_WRITE;
                    end
                end
                COPY_WRITE: begin
                    if (bus.ack) begin
                        count <= count_dec;
                        if (count_dec[16]) begin
                            bus.sel <= 1'b0;
                            bus.wr  <= 1'b0;
                            state   <= DONE;
                        end else begin
                            bus.xr       <= work_rd_xr;
                            bus.wr       <= 1'b0;
                            bus.addr     <= work_rd_addr;
                            work_rd_addr <= work_rd_addr + 1'b1;
                            state        <= COPY_READ;
                        end
                    end
                end
                FILL_WRITE: begin
                    if (bus.ack) begin
                        count <= count_dec;
                        if (count_dec[16]) begin
                            bus.sel <= 1'b0;
                            bus.wr  <= 1'b0;
                            state   <= DONE;
                        end else begin
                            bus.addr     <= work_wr_addr;  // same fill word
                            work_wr_addr <= work_wr_addr + 1'b1;
                        end
                    end
                end
                DONE: begin
                    if (queued) begin
                        state <= SETUP;  // busy stays high
                    end else begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/blit_mem_arb.sv
// memory arbiter for VRAM and XR
// host strobe wins, otherwise one blitter request is issued;
// returns read data with ack to the blitter or to the host port

`timescale 1ns/1ps

module blit_mem_arb #(
    parameter int VRAM_ADDR_W = 12,
    parameter int XR_ADDR_W   = 8
) (
    input  logic                   clk,
    input  logic                   reset_i,
    blit_bus_if.arb                bus,
    input  logic                   mem_req_i,
    input  logic                   mem_xr_i,
    input  logic                   mem_wr_i,
    input  blit_pkg::addr_t        mem_addr_i,
    input  blit_pkg::word_t        mem_wdata_i,
    output blit_pkg::word_t        mem_rdata_o,
    output logic                   vram_en_o,
    output logic [3:0]             vram_we_o,
    output logic [VRAM_ADDR_W-1:0] vram_addr_o,
    output blit_pkg::word_t        vram_wdata_o,
    input  blit_pkg::word_t        vram_rdata_i,
    output logic                   xr_en_o,
    output logic [3:0]             xr_we_o,
    output logic [XR_ADDR_W-1:0]   xr_addr_o,
    output blit_pkg::word_t        xr_wdata_o,
    input  blit_pkg::word_t        xr_rdata_i
);
    import blit_pkg::*;

    logic       blit_issued;  // blitter access in flight until its ack
    logic       blit_go;      // issue the blitter request this cycle
    logic       acc_en;
    logic       acc_xr;
    logic [3:0] acc_we;
    addr_t      acc_addr;
    word_t      acc_wdata;

    // access tracking, one cycle after issue
    logic  s1_blit;
    logic  s1_host_rd;
    logic  s1_xr;
    word_t s1_rdata;

    assign blit_go = bus.sel & ~blit_issued & ~mem_req_i;

    always_comb begin
        if (mem_req_i) begin
            acc_en    = 1'b1;
            acc_xr    = mem_xr_i;
            acc_we    = mem_wr_i ? 4'hF : 4'h0;  // host writes whole words
            acc_addr  = mem_addr_i;
            acc_wdata = mem_wdata_i;
        end else begin
            acc_en    = blit_go;
            acc_xr    = bus.xr;
            acc_we    = (blit_go & bus.wr) ? bus.wr_mask : 4'h0;
            acc_addr  = bus.addr;
            acc_wdata = bus.wdata;
        end
    end

    assign vram_en_o    = acc_en & ~acc_xr;
    assign vram_we_o    = acc_xr ? 4'h0 : acc_we;
    assign vram_addr_o  = acc_addr[VRAM_ADDR_W-1:0];
    assign vram_wdata_o = acc_wdata;

    assign xr_en_o    = acc_en & acc_xr;
    assign xr_we_o    = acc_xr ? acc_we : 4'h0;
    assign xr_addr_o  = acc_addr[XR_ADDR_W-1:0];
    assign xr_wdata_o = acc_wdata;

    assign s1_rdata = s1_xr ? xr_rdata_i : vram_rdata_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            blit_issued <= 1'b0;
            s1_blit     <= 1'b0;
            s1_host_rd  <= 1'b0;
            bus.ack     <= 1'b0;
            mem_rdata_o <= '0;
        end else begin
            s1_blit    <= blit_go;
            s1_host_rd <= mem_req_i & ~mem_wr_i;
            bus.ack    <= s1_blit;
            if (blit_go) begin
                blit_issued <= 1'b1;
            end else if (bus.ack) begin
                blit_issued <= 1'b0;  // engine shows next request after this
            end
            if (s1_host_rd) begin
                mem_rdata_o <= s1_rdata;  // two cycles after the strobe
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_xr     <= acc_xr;
        bus.rdata <= s1_rdata;
    end

endmodule

// File: logic/blit_pkg.sv
// shared types for the blitter subsystem
// word and address types, register numbers, MODE bit positions

package blit_pkg;

    typedef logic [15:0] word_t;      // data word, VRAM and XR alike
    typedef logic [15:0] addr_t;      // each RAM uses only the low bits
    typedef logic [3:0]  blit_reg_t;  // host register number

    // host register numbers
    // gaps belong to 2-D registers not built here, they read as zero
    localparam blit_reg_t BLIT_REG_MODE    = 4'h0;
    localparam blit_reg_t BLIT_REG_WR_MASK = 4'h3;  // low 4 bits, nibble enables
    localparam blit_reg_t BLIT_REG_RD_ADDR = 4'h5;  // also the fill value
    localparam blit_reg_t BLIT_REG_WR_ADDR = 4'h6;
    localparam blit_reg_t BLIT_REG_COUNT   = 4'h7;  // words minus one, starts a job

    // MODE register bits
    localparam int MODE_RD_XR = 15;  // read side is XR
    localparam int MODE_WR_XR = 14;  // write side is XR
    localparam int MODE_FILL  = 13;  // fill instead of copy

endpackage

// File: logic/blit_ram.sv
// single-port synchronous RAM, one-cycle read latency
// per-nibble write enables, write-first read data

`timescale 1ns/1ps

module blit_ram #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              en_i,
    input  logic [3:0]        we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  blit_pkg::word_t   wdata_i,
    output blit_pkg::word_t   rdata_o
);
    import blit_pkg::*;

    word_t mem [2**ADDR_W];
    word_t merged;  // stored word with enabled nibbles replaced

    always_comb begin
        merged = mem[addr_i];
        for (int n = 0; n < 4; n++) begin
            if (we_i[n]) begin
                merged[4*n +: 4] = wdata_i[4*n +: 4];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (|we_i) begin
                mem[addr_i] <= merged;
            end
            rdata_o <= merged;  // new contents on a write
        end
    end

endmodule

// File: logic/blit_top.sv
// blitter subsystem top level
// engine, memory arbiter, VRAM and XR RAMs

`timescale 1ns/1ps

module blit_top #(
    parameter int VRAM_ADDR_W = 12,
    parameter int XR_ADDR_W   = 8
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  blit_pkg::blit_reg_t reg_num_i,
    input  blit_pkg::word_t     reg_data_i,
    output blit_pkg::word_t     reg_data_o,
    input  logic                mem_req_i,
    input  logic                mem_xr_i,
    input  logic                mem_wr_i,
    input  blit_pkg::addr_t     mem_addr_i,
    input  blit_pkg::word_t     mem_wdata_i,
    output blit_pkg::word_t     mem_rdata_o,
    output logic                busy_o,
    output logic                done_intr_o
);
    import blit_pkg::*;

    // RAM side of the arbiter
    logic                   vram_en;
    logic [3:0]             vram_we;
    logic [VRAM_ADDR_W-1:0] vram_addr;
    word_t                  vram_wdata;
    word_t                  vram_rdata;
    logic                   xr_en;
    logic [3:0]             xr_we;
    logic [XR_ADDR_W-1:0]   xr_addr;
    word_t                  xr_wdata;
    word_t                  xr_rdata;

    blit_bus_if u_bus ();

    blit_engine u_engine (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr_i),
        .reg_num_i   (reg_num_i),
        .reg_data_i  (reg_data_i),
        .reg_data_o  (reg_data_o),
        .busy_o      (busy_o),
        .done_intr_o (done_intr_o),
        .bus         (u_bus.engine)
    );

    blit_mem_arb #(
        .VRAM_ADDR_W (VRAM_ADDR_W),
        .XR_ADDR_W   (XR_ADDR_W)
    ) u_arb (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus          (u_bus.arb),
        .mem_req_i    (mem_req_i),
        .mem_xr_i     (mem_xr_i),
        .mem_wr_i     (mem_wr_i),
        .mem_addr_i   (mem_addr_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_rdata_o  (mem_rdata_o),
        .vram_en_o    (vram_en),
        .vram_we_o    (vram_we),
        .vram_addr_o  (vram_addr),
        .vram_wdata_o (vram_wdata),
        .vram_rdata_i (vram_rdata),
        .xr_en_o      (xr_en),
        .xr_we_o      (xr_we),
        .xr_addr_o    (xr_addr),
        .xr_wdata_o   (xr_wdata),
        .xr_rdata_i   (xr_rdata)
    );

    blit_ram #(.ADDR_W(VRAM_ADDR_W)) u_vram (
        .clk     (clk),
        .en_i    (vram_en),
        .we_i    (vram_we),
        .addr_i  (vram_addr),
        .wdata_i (vram_wdata),
        .rdata_o (vram_rdata)
    );

    blit_ram #(.ADDR_W(XR_ADDR_W)) u_xr (
        .clk     (clk),
        .en_i    (xr_en),
        .we_i    (xr_we),
        .addr_i  (xr_addr),
        .wdata_i (xr_wdata),
        .rdata_o (xr_rdata)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the blitter testbench with Verilator, result taken from sim.log
rm -f sim.log
verilator --binary --assert --top-module blit_tb -f flist.f -o blit_sim \
    && ./obj_dir/blit_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Done: no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/blit_assert.sv
// concurrent checks on the blitter engine
// request bus stability, done pulse width, state right after reset

`timescale 1ns/1ps

module blit_assert (
    input logic            clk,
    input logic            reset_i,
    input logic            sel_i,
    input logic            xr_i,
    input logic            wr_i,
    input logic [3:0]      wr_mask_i,
    input blit_pkg::addr_t addr_i,
    input blit_pkg::word_t wdata_i,
    input logic            ack_i,
    input logic            busy_i,
    input logic            done_i
);

    // an open request may not move until the arbiter acks it
    property req_held;
        @(posedge clk) disable iff (reset_i)
            (sel_i && !ack_i) |=> (sel_i && $stable({xr_i, wr_i, wr_mask_i, addr_i, wdata_i}));
    endproperty

    // done follows the last acked access and drops after one cycle
    property done_single;
        @(posedge clk) disable iff (reset_i)
            done_i |=> (!done_i && $past(ack_i, 2));
    endproperty

    property idle_after_reset;
        @(posedge clk) reset_i |=> (!busy_i && !done_i);
    endproperty

    a_req_held: assert property (req_held)
        else $error("blitter request changed before ack");
    a_done_single: assert property (done_single)
        else $error("done pulse not one cycle after the last ack");
    a_idle_after_reset: assert property (idle_after_reset)
        else $error("engine busy or done right after reset");

endmodule

bind blit_engine blit_assert u_engine_assert (
    .clk       (clk),
    .reset_i   (reset_i),
    .sel_i     (bus.sel),
    .xr_i      (bus.xr),
    .wr_i      (bus.wr),
    .wr_mask_i (bus.wr_mask),
    .addr_i    (bus.addr),
    .wdata_i   (bus.wdata),
    .ack_i     (bus.ack),
    .busy_i    (busy_o),
    .done_i    (done_intr_o)
);

// File: verif/blit_clkgen.sv
// testbench clock source
// free running clock, 40 ns period

`timescale 1ns/1ps

module blit_clkgen #(
    parameter int HALF_NS = 20  // half period in ns
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(HALF_NS) clk_o = ~clk_o;

endmodule

// File: verif/blit_tb.sv
// testbench for the blitter subsystem
// replays the test data file against blit_top, counts done pulses,
// checks register readback and memory contents

`timescale 1ns/1ps

module blit_tb;
    import blit_pkg::*;

    localparam int CYCLE_LIMIT = 200;  // clock periods allowed per data line

    logic      clk;
    logic      reset_i;
    logic      reg_wr_i;
    blit_reg_t reg_num_i;
    word_t     reg_data_i;
    word_t     reg_data_o;
    logic      mem_req_i;
    logic      mem_xr_i;
    logic      mem_wr_i;
    addr_t     mem_addr_i;
    word_t     mem_wdata_i;
    word_t     mem_rdata_o;
    logic      busy_o;
    logic      done_intr_o;

    // one entry per data line
    byte unsigned op_q[$];
    logic [31:0]  arg_q[$];
    logic [31:0]  data_q[$];
    logic [31:0]  exp_q[$];
    logic         loaded = 1'b0;

    int   done_count      = 0;
    logic done_prev       = 1'b0;
    logic busy_after_done = 1'b0;  // busy_o in the cycle after the last pulse

    blit_clkgen u_clkgen (.clk_o(clk));

    blit_top u_blit_top (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr_i),
        .reg_num_i   (reg_num_i),
        .reg_data_i  (reg_data_i),
        .reg_data_o  (reg_data_o),
        .mem_req_i   (mem_req_i),
        .mem_xr_i    (mem_xr_i),
        .mem_wr_i    (mem_wr_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_rdata_o (mem_rdata_o),
        .busy_o      (busy_o),
        .done_intr_o (done_intr_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic load_testdata();
        int           fd;
        int           fields;
        string        line;
        byte unsigned op;
        logic [31:0]  arg;
        logic [31:0]  data;
        logic [31:0]  expv;
        fd = $fopen("verif/blit_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the test data file verif/blit_testdata.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin  // skip notes and blanks
                    fields = $sscanf(line, "%c %h %h %h", op, arg, data, expv);
                    if (fields != 4) begin
                        abort_run({"malformed line in the test data file: ", line});
                    end else begin
                        op_q.push_back(op);
                        arg_q.push_back(arg);
                        data_q.push_back(data);
                        exp_q.push_back(expv);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_reg(input logic [31:0] num, input logic [31:0] data);
        @(posedge clk);
        reg_wr_i   <= 1'b1;
        reg_num_i  <= num[3:0];
        reg_data_i <= data[15:0];
        @(posedge clk);
        reg_wr_i <= 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] num, input logic [31:0] exp);
        @(posedge clk);
        reg_num_i <= num[3:0];
        @(posedge clk);  // readback registered here
        @(negedge clk);
        check_value($sformatf("reg_data_o[%0h]", num), {16'h0, reg_data_o}, exp);
    endtask

    // address bit 16 selects XR
    task automatic write_mem(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        mem_req_i   <= 1'b1;
        mem_wr_i    <= 1'b1;
        mem_xr_i    <= addr[16];
        mem_addr_i  <= addr[15:0];
        mem_wdata_i <= data[15:0];
        @(posedge clk);
        mem_req_i <= 1'b0;
        mem_wr_i  <= 1'b0;
    endtask

    task automatic read_mem(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge clk);
        mem_req_i  <= 1'b1;
        mem_wr_i   <= 1'b0;
        mem_xr_i   <= addr[16];
        mem_addr_i <= addr[15:0];
        @(posedge clk);
        mem_req_i <= 1'b0;
        @(posedge clk);  // data due two cycles after the strobe
        @(negedge clk);
        check_value($sformatf("mem_rdata_o[%h]", addr), {16'h0, mem_rdata_o}, exp);
    endtask

    task automatic read_mem_in_job(input logic [31:0] addr, input logic [31:0] exp);
        int gap;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        read_mem(addr, exp);
        check_value("busy_o during host read", {31'h0, busy_o}, 32'h1);
    endtask

    task automatic wait_done(input logic [31:0] busy_exp, input logic [31:0] count_exp);
        while (done_count < int'(count_exp)) begin
            @(posedge clk);
        end
        check_value("done pulse count", done_count, count_exp);
        check_value("busy_o after done", {31'h0, busy_after_done}, busy_exp);
    endtask

    // counts done pulses and notes busy_o one cycle later
    always @(negedge clk) begin
        if (done_prev) begin
            busy_after_done = busy_o;
            done_count      = done_count + 1;
        end
        done_prev = done_intr_o;
    end

    initial begin
        wait (loaded);
        repeat ((op_q.size() + 1) * CYCLE_LIMIT) @(posedge clk);
        abort_run("timeout: the test data did not finish within the cycle limit");
    end

    initial begin
        reset_i     <= 1'b1;
        reg_wr_i    <= 1'b0;
        reg_num_i   <= '0;
        reg_data_i  <= '0;
        mem_req_i   <= 1'b0;
        mem_xr_i    <= 1'b0;
        mem_wr_i    <= 1'b0;
        mem_addr_i  <= '0;
        mem_wdata_i <= '0;
        void'($urandom(84));
        load_testdata();
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_value("busy_o after reset", {31'h0, busy_o}, 32'h0);
        check_value("done_intr_o after reset", {31'h0, done_intr_o}, 32'h0);
        check_value("mem_rdata_o after reset", {16'h0, mem_rdata_o}, 32'h0);

        foreach (op_q[i]) begin
            case (op_q[i])
                "W": write_reg(arg_q[i], data_q[i]);
                "R": read_reg(arg_q[i], exp_q[i]);
                "M": write_mem(arg_q[i], data_q[i]);
                "C": read_mem(arg_q[i], exp_q[i]);
                "D": wait_done(data_q[i], exp_q[i]);
                "H": read_mem_in_job(arg_q[i], exp_q[i]);
                default: abort_run($sformatf("unknown opcode on data line %0d", i));
            endcase
        end

        repeat (2) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: verif/blit_testdata.txt
# columns: op addr data expected, all hex; addr bit 16 selects XR for M, C and H
# ops W/R register write/check, M/C host write/check, H host read in a job, D data=busy after
# register readback
R 3 0 000f
R 0 0 0000
W 0 ffff 0
R 0 0 e000
W 3 00a5 0
R 3 0 0005
W 5 1234 0
R 5 0 1234
W 6 abcd 0
R 6 0 abcd
R 1 0 0000
# VRAM to VRAM copy, 3 words
M 0100 1111 0
M 0101 2222 0
M 0102 3333 0
M 0203 5a5a 0
W 0 0000 0
W 3 000f 0
W 5 0100 0
W 6 0200 0
W 7 0002 0
D 0 0 1
R 7 0 0002
C 0200 0 1111
C 0201 0 2222
C 0202 0 3333
C 0203 0 5a5a
# XR fill of 2 words, nibble mask 0101
M 10010 1234 0
M 10011 5678 0
M 10012 9abc 0
W 0 6000 0
W 3 0005 0
W 5 beef 0
W 6 0010 0
W 7 0001 0
D 0 0 2
C 10010 0 1e3f
C 10011 0 5e7f
C 10012 0 9abc
# XR to VRAM copy
M 10020 0a01 0
M 10021 0b02 0
W 0 8000 0
W 3 000f 0
W 5 0020 0
W 6 0300 0
W 7 0001 0
D 0 0 3
C 0300 0 0a01
C 0301 0 0b02
# second job programmed while the first runs
W 0 0000 0
W 5 0100 0
W 6 0400 0
W 7 0002 0
W 0 8000 0
W 5 0020 0
W 6 0500 0
W 7 0001 0
D 0 1 4
D 0 0 5
C 0400 0 1111
C 0401 0 2222
C 0402 0 3333
C 0500 0 0a01
C 0501 0 0b02
# host reads at random gaps during a 16 word VRAM fill
M 0600 6001 0
M 0601 6002 0
M 0602 6003 0
M 0a10 1357 0
W 0 2000 0
W 5 c0de 0
W 6 0a00 0
W 7 000f 0
H 0600 0 6001
H 10010 0 1e3f
H 0601 0 6002
H 0602 0 6003
D 0 0 6
C 0a00 0 c0de
C 0a0f 0 c0de
C 0a10 0 1357
